//--- husky_pkg.sv
package husky_pkg;

   // Register map, byte addresses on the USB register bus
   localparam logic [7:0] REG_ID_ADDR     = 8'h00;
   localparam logic [7:0] REG_CTRL_ADDR   = 8'h01;
   localparam logic [7:0] REG_CAPLEN_ADDR = 8'h02;
   localparam logic [7:0] REG_STATUS_ADDR = 8'h03;
   localparam logic [7:0] REG_COUNT_ADDR  = 8'h04;
   localparam logic [7:0] REG_FIFO_ADDR   = 8'h10;   // Streams capture FIFO, low byte first

   localparam logic [7:0] BOARD_ID = 8'h5A;

   // Control register bits
   localparam int CTRL_ARM_BIT     = 0;   // Self-clearing
   localparam int CTRL_SRC_BIT     = 1;   // 0 ADC, 1 logic analyzer
   localparam int CTRL_POWER_BIT   = 2;
   localparam int CTRL_CLR_ERR_BIT = 3;   // Self-clearing

   // Status register bits
   localparam int STAT_ARMED_BIT = 0;
   localparam int STAT_EMPTY_BIT = 1;
   localparam int STAT_OVF_BIT   = 2;
   localparam int STAT_UNF_BIT   = 3;

   // Both sample sources share this width
   localparam int SAMPLE_W = 12;

   typedef logic [SAMPLE_W-1:0] sample_t;

endpackage

//--- usb_reg_bus.sv
`timescale 1ns/1ps

module usb_reg_bus (
   input  logic       clk_usb_buf,
   input  logic       rst_n_i,
   input  logic [7:0] usb_addr_i,
   input  logic [7:0] usb_data_i,
   input  logic       usb_cen_i,
   input  logic       usb_rdn_i,
   input  logic       usb_wrn_i,
   input  logic [7:0] reg_rdata_i,
   output logic [7:0] usb_data_o,
   output logic       usb_data_oe_o,
   output logic [7:0] reg_addr_o,
   output logic [7:0] reg_wdata_o,
   output logic       reg_read_o,
   output logic       reg_write_o
);

   logic       wr_act;
   logic       rd_act;
   logic       wr_act_q;
   logic       rd_act_q;
   logic       wr_edge;
   logic       rd_edge;
   logic       rd_pend_q;   // Register block read data is valid this cycle
   logic [7:0] rd_hold_q;
   logic [7:0] rd_byte;

   // Strobes only count while the chip is selected
   assign wr_act  = ~usb_cen_i & ~usb_wrn_i;
   assign rd_act  = ~usb_cen_i & ~usb_rdn_i;
   assign wr_edge = wr_act & ~wr_act_q;
   assign rd_edge = rd_act & ~rd_act_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_act_q    <= 1'b0;
         rd_act_q    <= 1'b0;
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
         rd_pend_q   <= 1'b0;
         reg_addr_o  <= 8'h00;
      end else begin
         wr_act_q    <= wr_act;
         rd_act_q    <= rd_act;
         reg_write_o <= wr_edge;
         reg_read_o  <= rd_edge;
         rd_pend_q   <= reg_read_o;
         if (wr_edge || rd_edge) begin
            reg_addr_o <= usb_addr_i;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (wr_edge) begin
         reg_wdata_o <= usb_data_i;
      end
      if (rd_pend_q) begin
         rd_hold_q <= reg_rdata_i;   // Kept for the rest of the strobe
      end
   end

   assign rd_byte       = rd_pend_q ? reg_rdata_i : rd_hold_q;
   assign usb_data_oe_o = rd_act;
   assign usb_data_o    = usb_data_oe_o ? rd_byte : 8'h00;

   // Overlapping strobes would make the register blocks see both at once
   a_no_rd_wr_overlap : assert property (
      @(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(reg_read_o && reg_write_o)
   );

endmodule

//--- husky_ctrl_regs.sv
`timescale 1ns/1ps

module husky_ctrl_regs #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                                 clk_usb_buf,
   input  logic                                 rst_n_i,
   input  logic [7:0]                           reg_addr_i,
   input  logic [7:0]                           reg_wdata_i,
   input  logic                                 reg_read_i,
   input  logic                                 reg_write_i,
   input  logic [7:0]                           fifo_rbyte_i,
   input  logic                                 armed_i,
   input  logic                                 fifo_empty_i,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0]      fifo_count_i,
   input  logic                                 ovf_err_i,
   input  logic                                 unf_err_i,
   output logic [7:0]                           reg_rdata_o,
   output logic                                 arm_o,
   output logic                                 src_sel_o,
   output logic [7:0]                           cap_len_o,
   output logic                                 clear_err_o,
   output logic                                 target_power_o,
   output logic                                 target_io_oe_o
);

   logic       ctrl_wr;
   logic       caplen_wr;
   logic       src_q;
   logic       power_q;
   logic       io_en_q;     // Power has been up for at least a cycle
   logic [7:0] cap_len_q;
   logic [7:0] own_rdata;

   assign ctrl_wr   = reg_write_i && (reg_addr_i == husky_pkg::REG_CTRL_ADDR);
   assign caplen_wr = reg_write_i && (reg_addr_i == husky_pkg::REG_CAPLEN_ADDR);

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         src_q       <= 1'b0;
         power_q     <= 1'b0;
         io_en_q     <= 1'b0;
         cap_len_q   <= 8'h00;
         arm_o       <= 1'b0;
         clear_err_o <= 1'b0;
         reg_rdata_o <= 8'h00;
      end else begin
         // Arm and clear are pulses, never stored
         arm_o       <= ctrl_wr & reg_wdata_i[husky_pkg::CTRL_ARM_BIT];
         clear_err_o <= ctrl_wr & reg_wdata_i[husky_pkg::CTRL_CLR_ERR_BIT];
         io_en_q     <= power_q;
         if (ctrl_wr) begin
            src_q   <= reg_wdata_i[husky_pkg::CTRL_SRC_BIT];
            power_q <= reg_wdata_i[husky_pkg::CTRL_POWER_BIT];
         end
         if (caplen_wr) begin
            cap_len_q <= reg_wdata_i;
         end
         if (reg_read_i) begin
            reg_rdata_o <= own_rdata | fifo_rbyte_i;   // FIFO byte is 0 off its address
         end
      end
   end

   always_comb begin
      own_rdata = 8'h00;
      case (reg_addr_i)
         husky_pkg::REG_ID_ADDR: own_rdata = husky_pkg::BOARD_ID;
         husky_pkg::REG_CTRL_ADDR: begin
            own_rdata[husky_pkg::CTRL_SRC_BIT]   = src_q;
            own_rdata[husky_pkg::CTRL_POWER_BIT] = power_q;
         end
         husky_pkg::REG_CAPLEN_ADDR: own_rdata = cap_len_q;
         husky_pkg::REG_STATUS_ADDR: begin
            own_rdata[husky_pkg::STAT_ARMED_BIT] = armed_i;
            own_rdata[husky_pkg::STAT_EMPTY_BIT] = fifo_empty_i;
            own_rdata[husky_pkg::STAT_OVF_BIT]   = ovf_err_i;
            own_rdata[husky_pkg::STAT_UNF_BIT]   = unf_err_i;
         end
         husky_pkg::REG_COUNT_ADDR: own_rdata = 8'(fifo_count_i);
         default: own_rdata = 8'h00;
      endcase
   end

   assign src_sel_o      = src_q;
   assign cap_len_o      = cap_len_q;
   assign target_power_o = power_q;
   // Outputs wait a cycle for power, but drop with it at once
   assign target_io_oe_o = power_q & io_en_q;

endmodule

//--- capture_arbiter.sv
`timescale 1ns/1ps

module capture_arbiter (
   input  logic               clk_usb_buf,
   input  logic               rst_n_i,
   input  logic               arm_i,
   input  logic               src_sel_i,
   input  logic [7:0]         cap_len_i,
   input  husky_pkg::sample_t adc_sample_i,
   input  logic               adc_valid_i,
   input  husky_pkg::sample_t la_sample_i,
   input  logic               la_valid_i,
   input  logic               cap_ready_i,
   output husky_pkg::sample_t cap_sample_o,
   output logic               cap_valid_o,
   output logic               armed_o
);

   husky_pkg::sample_t sel_sample;
   logic               sel_valid;
   logic               xfer;
   logic               done;
   logic [7:0]         count_q;   // Accepted samples since arm

   assign sel_sample = src_sel_i ? la_sample_i : adc_sample_i;
   assign sel_valid  = src_sel_i ? la_valid_i : adc_valid_i;
   assign xfer       = cap_valid_o & cap_ready_i;
   // Length 0 runs until the next arm
   assign done       = xfer && (cap_len_i != 8'h00) && (count_q + 8'd1 == cap_len_i);

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         armed_o     <= 1'b0;
         cap_valid_o <= 1'b0;
         count_q     <= 8'h00;
      end else if (arm_i) begin
         armed_o     <= 1'b1;
         cap_valid_o <= 1'b0;
         count_q     <= 8'h00;
      end else begin
         cap_valid_o <= armed_o & sel_valid & ~done;   // No stray sample after the last
         if (xfer) begin
            count_q <= count_q + 8'd1;
         end
         if (done) begin
            armed_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (sel_valid) begin
         cap_sample_o <= sel_sample;
      end
   end

   a_valid_only_when_armed : assert property (
      @(posedge clk_usb_buf) disable iff (!rst_n_i)
      cap_valid_o |-> $past(armed_o)
   );

endmodule

//--- capture_fifo.sv
`timescale 1ns/1ps

module capture_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  husky_pkg::sample_t               cap_sample_i,
   input  logic                             cap_valid_i,
   input  logic                             flush_i,
   input  logic                             clear_err_i,
   input  logic [7:0]                       reg_addr_i,
   input  logic                             reg_read_i,
   output logic                             cap_ready_o,
   output logic [7:0]                       fifo_rbyte_o,
   output logic                             fifo_empty_o,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_count_o,
   output logic                             ovf_err_o,
   output logic                             unf_err_o
);

   localparam int AW    = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH+1);
   localparam logic [AW-1:0]    LAST_PTR = AW'(FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

   husky_pkg::sample_t mem [FIFO_DEPTH];
   logic [AW-1:0]      wr_ptr_q;
   logic [AW-1:0]      rd_ptr_q;
   logic               hi_phase_q;   // Next FIFO read returns the high byte
   logic               full;
   logic               wr_en;
   logic               fifo_rd;
   logic               pop;
   logic [15:0]        head_word;

   assign full         = (fifo_count_o == FULL_CNT);
   assign fifo_empty_o = (fifo_count_o == '0);
   assign cap_ready_o  = ~full;
   assign wr_en        = cap_valid_i & ~full;
   assign fifo_rd      = reg_read_i && (reg_addr_i == husky_pkg::REG_FIFO_ADDR);
   assign pop          = fifo_rd & ~fifo_empty_o & hi_phase_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         fifo_count_o <= '0;
         hi_phase_q   <= 1'b0;
         ovf_err_o    <= 1'b0;
         unf_err_o    <= 1'b0;
      end else begin
         if (flush_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            fifo_count_o <= '0;
            hi_phase_q   <= 1'b0;
         end else begin
            if (wr_en) begin
               wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
               rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            if (fifo_rd && !fifo_empty_o) begin
               hi_phase_q <= ~hi_phase_q;
            end
            case ({wr_en, pop})
               2'b10:   fifo_count_o <= fifo_count_o + 1'b1;
               2'b01:   fifo_count_o <= fifo_count_o - 1'b1;
               default: fifo_count_o <= fifo_count_o;
            endcase
         end
         // Sticky until cleared, a new error in the same cycle still wins
         if (clear_err_i) begin
            ovf_err_o <= 1'b0;
            unf_err_o <= 1'b0;
         end
         if (cap_valid_i && full) ovf_err_o <= 1'b1;   // Sample dropped
         if (fifo_rd && fifo_empty_o) unf_err_o <= 1'b1;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (wr_en && !flush_i) begin
         mem[wr_ptr_q] <= cap_sample_i;
      end
   end

   assign head_word = 16'(mem[rd_ptr_q]);

   always_comb begin
      fifo_rbyte_o = 8'h00;
      if (reg_addr_i == husky_pkg::REG_FIFO_ADDR && !fifo_empty_o) begin
         fifo_rbyte_o = hi_phase_q ? head_word[15:8] : head_word[7:0];
      end
   end

   a_count_in_range : assert property (
      @(posedge clk_usb_buf) disable iff (!rst_n_i)
      fifo_count_o <= FULL_CNT
   );

endmodule

//--- status_leds.sv
`timescale 1ns/1ps

module status_leds #(
   parameter int FLASH_DIV_BITS = 4
) (
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic armed_i,
   input  logic cap_valid_i,
   input  logic ovf_err_i,
   input  logic unf_err_i,
   output logic led_armed_o,
   output logic led_cap_o,
   output logic led_err_o
);

   // One extra bit so the stretch lasts the full 2^N cycles
   localparam logic [FLASH_DIV_BITS:0] STRETCH_LOAD = {1'b1, {FLASH_DIV_BITS{1'b0}}};

   logic [FLASH_DIV_BITS-1:0] div_q;
   logic [FLASH_DIV_BITS:0]   stretch_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         div_q     <= '0;
         stretch_q <= '0;
      end else begin
         div_q <= div_q + 1'b1;   // Free running
         if (cap_valid_i) begin
            stretch_q <= STRETCH_LOAD;
         end else if (stretch_q != '0) begin
            stretch_q <= stretch_q - 1'b1;
         end
      end
   end

   assign led_armed_o = armed_i;
   assign led_cap_o   = (stretch_q != '0);
   assign led_err_o   = (ovf_err_i | unf_err_i) & div_q[FLASH_DIV_BITS-1];

endmodule

//--- husky_top.sv
`timescale 1ns/1ps

module husky_top #(
   parameter int FIFO_DEPTH     = 16,
   parameter int FLASH_DIV_BITS = 4
) (
   input  logic               clk_usb_buf,
   input  logic               rst_n_i,
   input  logic [7:0]         usb_addr_i,
   input  logic [7:0]         usb_data_i,
   input  logic               usb_cen_i,
   input  logic               usb_rdn_i,
   input  logic               usb_wrn_i,
   output logic [7:0]         usb_data_o,
   output logic               usb_data_oe_o,
   input  husky_pkg::sample_t adc_sample_i,
   input  logic               adc_valid_i,
   input  husky_pkg::sample_t la_sample_i,
   input  logic               la_valid_i,
   output logic               target_power_o,
   output logic               target_io_oe_o,
   output logic               led_armed_o,
   output logic               led_cap_o,
   output logic               led_err_o
);

   localparam int CNT_W = $clog2(FIFO_DEPTH+1);

   logic [7:0]         reg_addr;
   logic [7:0]         reg_wdata;
   logic [7:0]         reg_rdata;
   logic               reg_read;
   logic               reg_write;
   logic [7:0]         fifo_rbyte;
   logic               fifo_empty;
   logic [CNT_W-1:0]   fifo_count;
   logic               ovf_err;
   logic               unf_err;
   logic               arm;
   logic               armed;
   logic               src_sel;
   logic [7:0]         cap_len;
   logic               clear_err;
   husky_pkg::sample_t cap_sample;
   logic               cap_valid;
   logic               cap_ready;

   usb_reg_bus u_usb_reg_bus (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_cen_i     (usb_cen_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_addr_o    (reg_addr),
      .reg_wdata_o   (reg_wdata),
      .reg_read_o    (reg_read),
      .reg_write_o   (reg_write)
   );

   husky_ctrl_regs #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_husky_ctrl_regs (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_addr_i     (reg_addr),
      .reg_wdata_i    (reg_wdata),
      .reg_read_i     (reg_read),
      .reg_write_i    (reg_write),
      .fifo_rbyte_i   (fifo_rbyte),
      .armed_i        (armed),
      .fifo_empty_i   (fifo_empty),
      .fifo_count_i   (fifo_count),
      .ovf_err_i      (ovf_err),
      .unf_err_i      (unf_err),
      .reg_rdata_o    (reg_rdata),
      .arm_o          (arm),
      .src_sel_o      (src_sel),
      .cap_len_o      (cap_len),
      .clear_err_o    (clear_err),
      .target_power_o (target_power_o),
      .target_io_oe_o (target_io_oe_o)
   );

   capture_arbiter u_capture_arbiter (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .arm_i        (arm),
      .src_sel_i    (src_sel),
      .cap_len_i    (cap_len),
      .adc_sample_i (adc_sample_i),
      .adc_valid_i  (adc_valid_i),
      .la_sample_i  (la_sample_i),
      .la_valid_i   (la_valid_i),
      .cap_ready_i  (cap_ready),
      .cap_sample_o (cap_sample),
      .cap_valid_o  (cap_valid),
      .armed_o      (armed)
   );

   // Arm pulse doubles as the FIFO flush
   capture_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_capture_fifo (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .cap_sample_i (cap_sample),
      .cap_valid_i  (cap_valid),
      .flush_i      (arm),
      .clear_err_i  (clear_err),
      .reg_addr_i   (reg_addr),
      .reg_read_i   (reg_read),
      .cap_ready_o  (cap_ready),
      .fifo_rbyte_o (fifo_rbyte),
      .fifo_empty_o (fifo_empty),
      .fifo_count_o (fifo_count),
      .ovf_err_o    (ovf_err),
      .unf_err_o    (unf_err)
   );

   status_leds #(
      .FLASH_DIV_BITS (FLASH_DIV_BITS)
   ) u_status_leds (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .armed_i     (armed),
      .cap_valid_i (cap_valid),
      .ovf_err_i   (ovf_err),
      .unf_err_i   (unf_err),
      .led_armed_o (led_armed_o),
      .led_cap_o   (led_cap_o),
      .led_err_o   (led_err_o)
   );

endmodule

//--- tb_husky_tasks.svh
`ifndef TB_HUSKY_TASKS_SVH
`define TB_HUSKY_TASKS_SVH

// Bus tasks start and end 1 ns after a rising edge
task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
   usb_addr_i = addr;
   usb_data_i = data;
   usb_cen_i  = 1'b0;
   usb_wrn_i  = 1'b0;
   repeat (4) @(posedge clk_usb_buf);
   #1;
   usb_cen_i = 1'b1;
   usb_wrn_i = 1'b1;
   @(posedge clk_usb_buf);   // Gap cycle
   #1;
endtask

task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
   usb_addr_i = addr;
   usb_cen_i  = 1'b0;
   usb_rdn_i  = 1'b0;
   repeat (3) @(posedge clk_usb_buf);
   #(CLK_PERIOD/4);   // Mid cycle of the last strobe cycle
   assert (usb_data_oe_o) else begin
      $display("usb_data_oe_o was low while the read strobe was held");
      stop_on_failure();
   end
   data = usb_data_o;
   @(posedge clk_usb_buf);
   #1;
   usb_cen_i = 1'b1;
   usb_rdn_i = 1'b1;
   @(posedge clk_usb_buf);
   #1;
endtask

task automatic read_and_check(input string test, input string what,
                              input logic [7:0] addr, input logic [7:0] expected);
   logic [7:0] data;
   bus_read(addr, data);
   check_value(test, what, expected, data);
endtask

task automatic write_control(input bit src, input bit power, input bit arm, input bit clr);
   logic [7:0] val;
   val = 8'h00;
   val[husky_pkg::CTRL_SRC_BIT]     = src;
   val[husky_pkg::CTRL_POWER_BIT]   = power;
   val[husky_pkg::CTRL_ARM_BIT]     = arm;
   val[husky_pkg::CTRL_CLR_ERR_BIT] = clr;
   bus_write(husky_pkg::REG_CTRL_ADDR, val);
endtask

function automatic logic [7:0] status_value(input bit armed, input bit empty,
                                            input bit ovf, input bit unf);
   logic [7:0] val;
   val = 8'h00;
   val[husky_pkg::STAT_ARMED_BIT] = armed;
   val[husky_pkg::STAT_EMPTY_BIT] = empty;
   val[husky_pkg::STAT_OVF_BIT]   = ovf;
   val[husky_pkg::STAT_UNF_BIT]   = unf;
   return val;
endfunction

// Both sources fire together on every other cycle
task automatic drive_samples(input int n);
   int i;
   for (i = 0; i < n; i++) begin
      rng_state    = xorshift32(rng_state);
      adc_sample_i = rng_state[husky_pkg::SAMPLE_W-1:0];
      rng_state    = xorshift32(rng_state);
      la_sample_i  = rng_state[husky_pkg::SAMPLE_W-1:0];
      adc_valid_i  = 1'b1;
      la_valid_i   = 1'b1;
      adc_sent.push_back(adc_sample_i);
      la_sent.push_back(la_sample_i);
      @(posedge clk_usb_buf);
      #1;
      adc_valid_i = 1'b0;
      la_valid_i  = 1'b0;
      @(posedge clk_usb_buf);
      #1;
   end
endtask

task automatic read_fifo_sample(input string test, input husky_pkg::sample_t s);
   read_and_check(test, "fifo low byte", husky_pkg::REG_FIFO_ADDR, s[7:0]);
   read_and_check(test, "fifo high byte", husky_pkg::REG_FIFO_ADDR, {4'h0, s[11:8]});
endtask

task automatic watch_led_err(input int cycles, output bit seen_hi, output bit seen_lo);
   int i;
   seen_hi = 1'b0;
   seen_lo = 1'b0;
   for (i = 0; i < cycles; i++) begin
      @(posedge clk_usb_buf);
      #1;
      if (led_err_o) seen_hi = 1'b1;
      else seen_lo = 1'b1;
   end
endtask

task automatic test_reset_and_id();
   check_value("reset_id", "usb_data_oe_o", 8'h00, {7'h0, usb_data_oe_o});
   check_value("reset_id", "target_power_o", 8'h00, {7'h0, target_power_o});
   check_value("reset_id", "target_io_oe_o", 8'h00, {7'h0, target_io_oe_o});
   check_value("reset_id", "leds", 8'h00, {5'h0, led_armed_o, led_cap_o, led_err_o});
   read_and_check("reset_id", "board id", husky_pkg::REG_ID_ADDR, husky_pkg::BOARD_ID);
   check_value("reset_id", "oe after read", 8'h00, {7'h0, usb_data_oe_o});
   bus_write(husky_pkg::REG_CAPLEN_ADDR, 8'hA7);
   read_and_check("reset_id", "capture length", husky_pkg::REG_CAPLEN_ADDR, 8'hA7);
   // Arm and clear read back as 0
   write_control(1'b1, 1'b1, 1'b1, 1'b1);
   read_and_check("reset_id", "control", husky_pkg::REG_CTRL_ADDR,
                  (8'h01 << husky_pkg::CTRL_SRC_BIT) | (8'h01 << husky_pkg::CTRL_POWER_BIT));
   check_value("reset_id", "target_power_o on", 8'h01, {7'h0, target_power_o});
   check_value("reset_id", "target_io_oe_o on", 8'h01, {7'h0, target_io_oe_o});
   write_control(1'b0, 1'b0, 1'b0, 1'b0);
   read_and_check("reset_id", "control cleared", husky_pkg::REG_CTRL_ADDR, 8'h00);
   check_value("reset_id", "target_power_o off", 8'h00, {7'h0, target_power_o});
   check_value("reset_id", "target_io_oe_o off", 8'h00, {7'h0, target_io_oe_o});
endtask

task automatic capture_test(input string test, input bit use_la);
   int i;
   adc_sent.delete();
   la_sent.delete();
   bus_write(husky_pkg::REG_CAPLEN_ADDR, 8'd5);
   write_control(use_la, 1'b0, 1'b1, 1'b0);
   drive_samples(8);   // Three more than the length
   // Last capture was a few cycles ago, still inside the stretch
   check_value(test, "led_cap_o during capture", 8'h01, {7'h0, led_cap_o});
   read_and_check(test, "status", husky_pkg::REG_STATUS_ADDR, status_value(0, 0, 0, 0));
   read_and_check(test, "count", husky_pkg::REG_COUNT_ADDR, 8'd5);
   for (i = 0; i < 5; i++) begin
      if (use_la) read_fifo_sample(test, la_sent[i]);
      else read_fifo_sample(test, adc_sent[i]);
   end
   read_and_check(test, "status drained", husky_pkg::REG_STATUS_ADDR,
                  status_value(0, 1, 0, 0));
   check_value(test, "led_cap_o after stretch", 8'h00, {7'h0, led_cap_o});
endtask

task automatic test_adc_capture();
   capture_test("adc_capture", 1'b0);
endtask

task automatic test_la_capture();
   capture_test("la_capture", 1'b1);
endtask

task automatic test_overflow();
   bit seen_hi;
   bit seen_lo;
   int i;
   adc_sent.delete();
   la_sent.delete();
   bus_write(husky_pkg::REG_CAPLEN_ADDR, 8'd0);   // Unlimited length
   write_control(1'b0, 1'b0, 1'b1, 1'b0);
   check_value("overflow", "led_armed_o", 8'h01, {7'h0, led_armed_o});
   drive_samples(20);
   read_and_check("overflow", "count", husky_pkg::REG_COUNT_ADDR, 8'(FIFO_DEPTH));
   read_and_check("overflow", "status", husky_pkg::REG_STATUS_ADDR, status_value(1, 0, 1, 0));
   watch_led_err(64, seen_hi, seen_lo);
   assert (seen_hi && seen_lo) else begin
      $display("led_err_o did not flash within 64 cycles of the overflow");
      stop_on_failure();
   end
   write_control(1'b0, 1'b0, 1'b0, 1'b1);
   read_and_check("overflow", "status cleared", husky_pkg::REG_STATUS_ADDR,
                  status_value(1, 0, 0, 0));
   watch_led_err(64, seen_hi, seen_lo);
   assert (!seen_hi) else begin
      $display("led_err_o lit after the errors were cleared");
      stop_on_failure();
   end
   for (i = 0; i < FIFO_DEPTH; i++) begin
      read_fifo_sample("overflow", adc_sent[i]);
   end
   read_and_check("overflow", "status drained", husky_pkg::REG_STATUS_ADDR,
                  status_value(1, 1, 0, 0));
endtask

task automatic test_underflow();
   read_and_check("underflow", "empty fifo read", husky_pkg::REG_FIFO_ADDR, 8'h00);
   read_and_check("underflow", "status", husky_pkg::REG_STATUS_ADDR, status_value(1, 1, 0, 1));
   adc_sent.delete();
   la_sent.delete();
   drive_samples(3);
   read_and_check("underflow", "count before arm", husky_pkg::REG_COUNT_ADDR, 8'd3);
   write_control(1'b0, 1'b0, 1'b1, 1'b0);   // Re-arm flushes
   read_and_check("underflow", "count after arm", husky_pkg::REG_COUNT_ADDR, 8'd0);
   read_and_check("underflow", "status after arm", husky_pkg::REG_STATUS_ADDR,
                  status_value(1, 1, 0, 1));
   write_control(1'b0, 1'b0, 1'b0, 1'b1);
   read_and_check("underflow", "status cleared", husky_pkg::REG_STATUS_ADDR,
                  status_value(1, 1, 0, 0));
endtask

`endif

//--- tb_husky_top.sv
`timescale 1ns/1ps

module tb_husky_top;

   localparam int  CLK_PERIOD     = 100;
   localparam int  TIMEOUT_CYCLES = 3000;   // About 90 bus accesses plus sample and LED waits
   localparam int  FIFO_DEPTH     = 16;

   logic               clk_usb_buf;
   logic               rst_n_i;
   logic [7:0]         usb_addr_i;
   logic [7:0]         usb_data_i;
   logic               usb_cen_i;
   logic               usb_rdn_i;
   logic               usb_wrn_i;
   logic [7:0]         usb_data_o;
   logic               usb_data_oe_o;
   husky_pkg::sample_t adc_sample_i;
   logic               adc_valid_i;
   husky_pkg::sample_t la_sample_i;
   logic               la_valid_i;
   logic               target_power_o;
   logic               target_io_oe_o;
   logic               led_armed_o;
   logic               led_cap_o;
   logic               led_err_o;

   logic [31:0]        rng_state;
   int                 cycle_count = 0;
   husky_pkg::sample_t adc_sent [$];   // Every sample offered on each source
   husky_pkg::sample_t la_sent [$];

   husky_top u_husky_top (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .usb_addr_i     (usb_addr_i),
      .usb_data_i     (usb_data_i),
      .usb_cen_i      (usb_cen_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o),
      .adc_sample_i   (adc_sample_i),
      .adc_valid_i    (adc_valid_i),
      .la_sample_i    (la_sample_i),
      .la_valid_i     (la_valid_i),
      .target_power_o (target_power_o),
      .target_io_oe_o (target_io_oe_o),
      .led_armed_o    (led_armed_o),
      .led_cap_o      (led_cap_o),
      .led_err_o      (led_err_o)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD/2) clk_usb_buf = ~clk_usb_buf;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_on_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [7:0] expected, input logic [7:0] actual);
      assert (actual === expected) else begin
         $display("Error: test %s, %s expected 0x%02h actual 0x%02h",
                  test, what, expected, actual);
         stop_on_failure();
      end
   endtask

   `include "tb_husky_tasks.svh"

   // Hard limit on run length
   always @(posedge clk_usb_buf) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_on_failure();
      end
   end

   initial begin
      rng_state    = 32'd53641;
      rst_n_i      = 1'b0;
      usb_addr_i   = 8'h00;
      usb_data_i   = 8'h00;
      usb_cen_i    = 1'b1;   // Bus idle with all strobes high
      usb_rdn_i    = 1'b1;
      usb_wrn_i    = 1'b1;
      adc_sample_i = '0;
      adc_valid_i  = 1'b0;
      la_sample_i  = '0;
      la_valid_i   = 1'b0;
      repeat (5) @(posedge clk_usb_buf);
      #1;
      rst_n_i = 1'b1;
      @(posedge clk_usb_buf);
      #1;

      test_reset_and_id();
      test_adc_capture();
      test_la_capture();
      test_overflow();
      test_underflow();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- husky_top.f
+incdir+.
husky_pkg.sv
usb_reg_bus.sv
husky_ctrl_regs.sv
capture_arbiter.sv
capture_fifo.sv
status_leds.sv
husky_top.sv
tb_husky_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_husky_top -f husky_top.f \
   --Mdir obj_dir -o tb_husky_top

./obj_dir/tb_husky_top 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "run_sim: pass"
else
   echo "run_sim: fail"
   exit 1
fi
